//--- hdl/decode_pkg.sv
package decode_pkg;

  localparam int XLEN  = 32;
  localparam int REG_W = 5;

  ////////////////////////////////////////
  // Base opcodes
  ////////////////////////////////////////
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;

  ////////////////////////////////////////
  // ALU operations, {funct7[5], funct3}
  ////////////////////////////////////////
  localparam logic [3:0] ALU_ADD  = 4'b0000;
  localparam logic [3:0] ALU_SUB  = 4'b1000;
  localparam logic [3:0] ALU_SLL  = 4'b0001;
  localparam logic [3:0] ALU_SLT  = 4'b0010;
  localparam logic [3:0] ALU_SLTU = 4'b0011;
  localparam logic [3:0] ALU_XOR  = 4'b0100;
  localparam logic [3:0] ALU_SRL  = 4'b0101;
  localparam logic [3:0] ALU_SRA  = 4'b1101;
  localparam logic [3:0] ALU_OR   = 4'b0110;
  localparam logic [3:0] ALU_AND  = 4'b0111;

  // One instruction word, six field layouts
  typedef union packed {
    struct packed {
      logic [6:0]       funct7;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [2:0]       funct3;
      logic [REG_W-1:0] rd;
      logic [6:0]       opcode;
    } r;
    struct packed {
      logic [11:0]      imm;
      logic [REG_W-1:0] rs1;
      logic [2:0]       funct3;
      logic [REG_W-1:0] rd;
      logic [6:0]       opcode;
    } i;
    struct packed {
      logic [6:0]       imm_hi;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [2:0]       funct3;
      logic [4:0]       imm_lo;
      logic [6:0]       opcode;
    } s;
    struct packed {
      logic             imm_12;
      logic [5:0]       imm_10_5;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [2:0]       funct3;
      logic [3:0]       imm_4_1;
      logic             imm_11;
      logic [6:0]       opcode;
    } b;
    struct packed {
      logic [19:0]      imm;
      logic [REG_W-1:0] rd;
      logic [6:0]       opcode;
    } u;
    struct packed {
      logic             imm_20;
      logic [9:0]       imm_10_1;
      logic             imm_11;
      logic [7:0]       imm_19_12;
      logic [REG_W-1:0] rd;
      logic [6:0]       opcode;
    } j;
  } instr_u;

endpackage

//--- hdl/control_decoder.sv
`timescale 1ns/1ns

module control_decoder
  import decode_pkg::*;
(
  input  instr_u     instr,
  output logic [3:0] alu_op,
  output logic       alu_src,
  output logic       mem_read,
  output logic       mem_write,
  output logic [2:0] mem_size,
  output logic       reg_write,
  output logic       branch,
  output logic       jal,
  output logic       lui,
  output logic       illegal
);

  always_comb begin
    alu_op    = ALU_ADD;
    alu_src   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    mem_size  = 3'b000;
    reg_write = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    lui       = 1'b0;
    illegal   = 1'b0;

    case (instr.r.opcode)
      OP_REG: begin
        reg_write = 1'b1;
        alu_op    = {instr.r.funct7[5], instr.r.funct3};
        // Alternate encoding exists only for SUB and SRA
        if (instr.r.funct7 == 7'b0100000) begin
          illegal = !(instr.r.funct3 inside {3'b000, 3'b101});
        end else begin
          illegal = instr.r.funct7 != 7'b0000000;
        end
      end
      OP_IMM: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        alu_op    = {1'b0, instr.i.funct3};
        // Upper immediate bits act as funct7 for shifts only
        if (instr.i.funct3 == 3'b001) begin
          illegal = instr.r.funct7 != 7'b0000000;
        end else if (instr.i.funct3 == 3'b101) begin
          alu_op[3] = instr.r.funct7[5];
          illegal   = !(instr.r.funct7 inside {7'b0000000, 7'b0100000});
        end
      end
      OP_LOAD: begin
        mem_read  = 1'b1;
        reg_write = 1'b1;
        alu_src   = 1'b1;
        mem_size  = instr.i.funct3;
        illegal   = !(instr.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
      end
      OP_STORE: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
        mem_size  = instr.i.funct3;
        illegal   = !(instr.i.funct3 inside {3'b000, 3'b001, 3'b010});
      end
      OP_BRANCH: begin
        branch  = 1'b1;
        alu_op  = ALU_SUB;
        illegal = instr.i.funct3 inside {3'b010, 3'b011};
      end
      OP_JAL: begin
        jal       = 1'b1;
        reg_write = 1'b1;
      end
      OP_LUI: begin
        lui       = 1'b1;
        reg_write = 1'b1;
        alu_src   = 1'b1;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // Nothing of an illegal word reaches execute
    if (illegal) begin
      alu_op    = ALU_ADD;
      alu_src   = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      mem_size  = 3'b000;
      reg_write = 1'b0;
      branch    = 1'b0;
      jal       = 1'b0;
      lui       = 1'b0;
    end
  end

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ns

module imm_gen
  import decode_pkg::*;
(
  input  instr_u          instr,
  output logic [XLEN-1:0] imm
);

  always_comb begin
    case (instr.i.opcode)
      OP_IMM, OP_LOAD: begin
        imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      OP_STORE: begin
        imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
      end
      // Branch offsets are in half words
      OP_BRANCH: begin
        imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      OP_JAL: begin
        imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      OP_LUI: begin
        imm = {instr.u.imm, 12'h000};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit
  import decode_pkg::*;
#(
  parameter int PC_W = 16
) (
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  input  logic [2:0]      funct3,
  input  logic            branch,
  input  logic            jal,
  input  logic [XLEN-1:0] imm,
  input  logic [PC_W-1:0] pc,
  output logic            taken,
  output logic [PC_W-1:0] target
);

  logic equal;
  logic less_signed;
  logic less_unsigned;
  logic condition;

  assign equal         = rs1_data == rs2_data;
  assign less_signed   = $signed(rs1_data) < $signed(rs2_data);
  assign less_unsigned = rs1_data < rs2_data;

  // Odd funct3 values invert the even compare
  always_comb begin
    case (funct3)
      3'b000:  condition = equal;
      3'b001:  condition = !equal;
      3'b100:  condition = less_signed;
      3'b101:  condition = !less_signed;
      3'b110:  condition = less_unsigned;
      3'b111:  condition = !less_unsigned;
      default: condition = 1'b0;
    endcase
  end

  assign taken  = jal || (branch && condition);
  assign target = pc + imm[PC_W-1:0];

endmodule

//--- hdl/credit_counter.sv
`timescale 1ns/1ns

module credit_counter #(
  parameter int CREDITS = 4
) (
  input  logic bus,
  input  logic reset,
  input  logic issue,
  input  logic credit_return,
  output logic available
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] count;

  // Issue and return in one cycle cancel out
  always_ff @(posedge bus) begin
    if (reset) begin
      count <= CNT_W'(CREDITS);
    end else begin
      case ({issue, credit_return})
        2'b10: begin
          if (count != '0) begin
            count <= count - 1'b1;
          end
        end
        2'b01: begin
          if (count != CNT_W'(CREDITS)) begin
            count <= count + 1'b1;
          end
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  assign available = count != '0;

endmodule

//--- hdl/decode_fsm.sv
`timescale 1ns/1ns

module decode_fsm
  import decode_pkg::*;
(
  input  logic             bus,
  input  logic             reset,
  input  logic             instr_valid,
  input  instr_u           instr,
  input  logic             available,
  input  logic             credit_return,
  input  logic             last_load,
  input  logic [REG_W-1:0] last_rd,
  input  logic             taken,
  input  logic             illegal_in,
  output logic             hold,
  output logic             accept,
  output logic             issue,
  output logic             redirect,
  output logic             illegal
);

  localparam logic [1:0] RUN        = 2'd0;
  localparam logic [1:0] LOAD_STALL = 2'd1;
  localparam logic [1:0] FLUSH      = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;
  logic       reads_rs1;
  logic       reads_rs2;
  logic       load_use;
  logic       no_credit;
  logic       flushing;

  assign flushing = state == FLUSH;

  // LUI and JAL have no source registers
  assign reads_rs1 = !(instr.r.opcode inside {OP_LUI, OP_JAL});
  assign reads_rs2 = instr.r.opcode inside {OP_REG, OP_STORE, OP_BRANCH};

  assign load_use = instr_valid && state == RUN && last_load &&
                    ((reads_rs1 && instr.r.rs1 != '0 && instr.r.rs1 == last_rd) ||
                     (reads_rs2 && instr.r.rs2 != '0 && instr.r.rs2 == last_rd));

  // A returning credit is usable in its own cycle
  assign no_credit = !available && !credit_return && !(instr_valid && illegal_in);

  // The wrong-path word is swallowed without waiting
  assign hold     = !flushing && (load_use || no_credit);
  assign accept   = instr_valid && !hold;
  assign issue    = accept && !flushing && !illegal_in;
  assign redirect = accept && !flushing && taken;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      RUN: begin
        if (load_use) begin
          state_next = LOAD_STALL;
        end else if (redirect) begin
          state_next = FLUSH;
        end
      end
      LOAD_STALL: begin
        if (redirect) begin
          state_next = FLUSH;
        end else if (accept) begin
          state_next = RUN;
        end
      end
      FLUSH: begin
        if (accept) begin
          state_next = RUN;
        end
      end
      default: begin
        state_next = RUN;
      end
    endcase
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      state   <= RUN;
      illegal <= 1'b0;
    end else begin
      state   <= state_next;
      illegal <= accept && !flushing && illegal_in;
    end
  end

endmodule

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg
  import decode_pkg::*;
#(
  parameter int PC_W = 16
) (
  input  logic             bus,
  input  logic             reset,
  input  logic             issue,
  input  logic [PC_W-1:0]  pc,
  input  logic [XLEN-1:0]  rs1_data,
  input  logic [XLEN-1:0]  rs2_data,
  input  logic [XLEN-1:0]  imm,
  input  logic [REG_W-1:0] rs1,
  input  logic [REG_W-1:0] rs2,
  input  logic [REG_W-1:0] rd,
  input  logic [3:0]       alu_op,
  input  logic             alu_src,
  input  logic             mem_read,
  input  logic             mem_write,
  input  logic [2:0]       mem_size,
  input  logic             reg_write,
  input  logic             jal,
  input  logic             lui,
  output logic             ex_valid,
  output logic [PC_W-1:0]  ex_pc,
  output logic [XLEN-1:0]  ex_rs1_data,
  output logic [XLEN-1:0]  ex_rs2_data,
  output logic [XLEN-1:0]  ex_imm,
  output logic [REG_W-1:0] ex_rs1,
  output logic [REG_W-1:0] ex_rs2,
  output logic [REG_W-1:0] ex_rd,
  output logic [3:0]       ex_alu_op,
  output logic             ex_alu_src,
  output logic             ex_mem_read,
  output logic             ex_mem_write,
  output logic [2:0]       ex_mem_size,
  output logic             ex_reg_write,
  output logic             ex_jal,
  output logic             ex_lui,
  output logic             last_load,
  output logic [REG_W-1:0] last_rd
);

  // Valid and enables
  always_ff @(posedge bus) begin
    if (reset) begin
      ex_valid     <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
    end else begin
      ex_valid <= issue;
      if (issue) begin
        ex_mem_read  <= mem_read;
        ex_mem_write <= mem_write;
        ex_reg_write <= reg_write;
      end
    end
  end

  // Operands and the rest of the controls
  always_ff @(posedge bus) begin
    if (issue) begin
      ex_pc       <= pc;
      ex_rs1_data <= rs1_data;
      ex_rs2_data <= rs2_data;
      ex_imm      <= imm;
      ex_rs1      <= rs1;
      ex_rs2      <= rs2;
      ex_rd       <= rd;
      ex_alu_op   <= alu_op;
      ex_alu_src  <= alu_src;
      ex_mem_size <= mem_size;
      ex_jal      <= jal;
      ex_lui      <= lui;
    end
  end

  // Load issued last cycle, for the hazard check
  assign last_load = ex_valid && ex_mem_read;
  assign last_rd   = ex_rd;

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
  import decode_pkg::*;
#(
  parameter int PC_W    = 16,
  parameter int CREDITS = 4
) (
  input  logic             bus,
  input  logic             reset,
  input  logic             instr_valid,
  input  logic [31:0]      instr,
  input  logic [PC_W-1:0]  instr_pc,
  input  logic [XLEN-1:0]  rs1_data,
  input  logic [XLEN-1:0]  rs2_data,
  input  logic             credit_return,
  output logic             hold,
  output logic             redirect,
  output logic [PC_W-1:0]  redirect_pc,
  output logic             illegal,
  output logic             ex_valid,
  output logic [PC_W-1:0]  ex_pc,
  output logic [XLEN-1:0]  ex_rs1_data,
  output logic [XLEN-1:0]  ex_rs2_data,
  output logic [XLEN-1:0]  ex_imm,
  output logic [REG_W-1:0] ex_rs1,
  output logic [REG_W-1:0] ex_rs2,
  output logic [REG_W-1:0] ex_rd,
  output logic [3:0]       ex_alu_op,
  output logic             ex_alu_src,
  output logic             ex_mem_read,
  output logic             ex_mem_write,
  output logic [2:0]       ex_mem_size,
  output logic             ex_reg_write,
  output logic             ex_jal,
  output logic             ex_lui
);

  instr_u           instr_word;
  logic [3:0]       alu_op;
  logic             alu_src;
  logic             mem_read;
  logic             mem_write;
  logic [2:0]       mem_size;
  logic             reg_write;
  logic             branch;
  logic             jal;
  logic             lui;
  logic             dec_illegal;
  logic [XLEN-1:0]  imm;
  logic             taken;
  logic             available;
  logic             issue;
  logic             last_load;
  logic [REG_W-1:0] last_rd;

  assign instr_word = instr;

  ////////////////////////////////////////
  // Combinational decode
  ////////////////////////////////////////
  control_decoder u_control_decoder (
    .instr     (instr_word),
    .alu_op    (alu_op),
    .alu_src   (alu_src),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_size  (mem_size),
    .reg_write (reg_write),
    .branch    (branch),
    .jal       (jal),
    .lui       (lui),
    .illegal   (dec_illegal)
  );

  imm_gen u_imm_gen (
    .instr (instr_word),
    .imm   (imm)
  );

  // Resolved here so fetch turns around at once
  branch_unit #(
    .PC_W (PC_W)
  ) u_branch_unit (
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .funct3   (instr_word.r.funct3),
    .branch   (branch),
    .jal      (jal),
    .imm      (imm),
    .pc       (instr_pc),
    .taken    (taken),
    .target   (redirect_pc)
  );

  ////////////////////////////////////////
  // Flow control and ID/EX register
  ////////////////////////////////////////
  credit_counter #(
    .CREDITS (CREDITS)
  ) u_credit_counter (
    .bus           (bus),
    .reset         (reset),
    .issue         (issue),
    .credit_return (credit_return),
    .available     (available)
  );

  decode_fsm u_decode_fsm (
    .bus           (bus),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .instr         (instr_word),
    .available     (available),
    .credit_return (credit_return),
    .last_load     (last_load),
    .last_rd       (last_rd),
    .taken         (taken),
    .illegal_in    (dec_illegal),
    .hold          (hold),
    .accept        (),
    .issue         (issue),
    .redirect      (redirect),
    .illegal       (illegal)
  );

  id_ex_reg #(
    .PC_W (PC_W)
  ) u_id_ex_reg (
    .bus          (bus),
    .reset        (reset),
    .issue        (issue),
    .pc           (instr_pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .rs1          (instr_word.r.rs1),
    .rs2          (instr_word.r.rs2),
    .rd           (instr_word.r.rd),
    .alu_op       (alu_op),
    .alu_src      (alu_src),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_size     (mem_size),
    .reg_write    (reg_write),
    .jal          (jal),
    .lui          (lui),
    .ex_valid     (ex_valid),
    .ex_pc        (ex_pc),
    .ex_rs1_data  (ex_rs1_data),
    .ex_rs2_data  (ex_rs2_data),
    .ex_imm       (ex_imm),
    .ex_rs1       (ex_rs1),
    .ex_rs2       (ex_rs2),
    .ex_rd        (ex_rd),
    .ex_alu_op    (ex_alu_op),
    .ex_alu_src   (ex_alu_src),
    .ex_mem_read  (ex_mem_read),
    .ex_mem_write (ex_mem_write),
    .ex_mem_size  (ex_mem_size),
    .ex_reg_write (ex_reg_write),
    .ex_jal       (ex_jal),
    .ex_lui       (ex_lui),
    .last_load    (last_load),
    .last_rd      (last_rd)
  );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic bus,
  output logic reset
);

  initial begin
    bus = 1'b0;
    forever #(PERIOD / 2) bus = ~bus;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus);
    reset <= 1'b0;
  end

endmodule

//--- verif/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage
  import decode_pkg::*;
;

  localparam int PC_W    = 16;
  localparam int CREDITS = 4;
  // Words sent by all tests, wrong-path words included
  localparam int N_INSTR = 16 + 3 + 26 + 8 + (CREDITS + 2) + (2 * CREDITS + 1);

  logic             bus, reset;
  logic             instr_valid, credit_return;
  logic [31:0]      instr;
  logic [PC_W-1:0]  instr_pc;
  logic [XLEN-1:0]  rs1_data, rs2_data;
  logic             hold, redirect, illegal, ex_valid;
  logic [PC_W-1:0]  redirect_pc, ex_pc;
  logic [XLEN-1:0]  ex_rs1_data, ex_rs2_data, ex_imm;
  logic [REG_W-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [3:0]       ex_alu_op;
  logic             ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write, ex_jal, ex_lui;
  logic [2:0]       ex_mem_size;
  logic             auto_return;
  logic [31:0]      rng;
  int               errors;

  tb_clock #(.PERIOD(100), .RESET_CYCLES(8)) u_clock (.bus(bus), .reset(reset));

  decode_stage #(.PC_W(PC_W), .CREDITS(CREDITS)) DUT (
    .bus(bus), .reset(reset), .instr_valid(instr_valid), .instr(instr),
    .instr_pc(instr_pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .credit_return(credit_return), .hold(hold), .redirect(redirect),
    .redirect_pc(redirect_pc), .illegal(illegal), .ex_valid(ex_valid), .ex_pc(ex_pc),
    .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data), .ex_imm(ex_imm),
    .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_alu_op(ex_alu_op),
    .ex_alu_src(ex_alu_src), .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
    .ex_mem_size(ex_mem_size), .ex_reg_write(ex_reg_write), .ex_jal(ex_jal),
    .ex_lui(ex_lui)
  );

  // Execute side frees each slot one cycle after it fills
  always @(posedge bus) begin
    if (reset) begin
      credit_return <= 1'b0;
    end else if (auto_return) begin
      credit_return <= ex_valid;
    end
  end

  ////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////
  task automatic fail_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_reg(input string name, input logic [REG_W-1:0] got,
                           input logic [REG_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_op(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  // xorshift32
  function logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [4:0] r;
    r = rand32();
    return (r == 0) ? 5'd1 : r;
  endfunction

  // Encoders follow the ISA bit layout
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  ////////////////////////////////////////
  // Fetch side
  ////////////////////////////////////////
  // Called just after a rising edge; returns at the accepting edge
  task automatic send(input logic [31:0] w, input logic [PC_W-1:0] pc,
                      input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                      output int holds, output logic red, output logic [PC_W-1:0] red_pc);
    instr_valid <= 1'b1;
    instr       <= w;
    instr_pc    <= pc;
    rs1_data    <= a;
    rs2_data    <= b;
    holds = 0;
    @(negedge bus);
    while (hold) begin
      holds++;
      if (holds > 50) begin
        fail_run("Fetch word was never accepted, hold stuck high");
      end
      @(negedge bus);
    end
    red    = redirect;
    red_pc = redirect_pc;
    @(posedge bus);
    instr_valid <= 1'b0;
  endtask

  // Cycle after acceptance
  task automatic check_out(input logic exp_issue, input logic exp_illegal);
    @(negedge bus);
    check_bit("ex_valid", ex_valid, exp_issue);
    check_bit("illegal", illegal, exp_illegal);
  endtask

  task automatic return_credits(input int n);
    repeat (n) begin
      credit_return <= 1'b1;
      @(posedge bus);
      credit_return <= 1'b0;
      @(posedge bus);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_alu();
    logic [31:0] a, b;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rs1, rs2, rd;
    int          h;
    logic        red;
    logic [PC_W-1:0] rpc;
    for (int n = 0; n < 16; n++) begin
      a = rand32();
      b = rand32();
      imm = rand32();
      f3 = rand32();
      rs1 = rand_reg();
      rs2 = rand_reg();
      rd = rand_reg();
      alt = (f3 == 3'b000 || f3 == 3'b101) ? rand32() : 1'b0;
      if (n % 2 == 0) begin
        send(enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd), 16'h0100, a, b, h, red, rpc);
        check_out(1'b1, 1'b0);
        check_op("ex_alu_op", ex_alu_op, {alt, f3});
        check_bit("ex_alu_src", ex_alu_src, 1'b0);
        check_word("ex_rs2_data", ex_rs2_data, b);
        check_reg("ex_rs2", ex_rs2, rs2);
      end else begin
        // Shift immediates carry funct7 in the upper bits
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm[11:5] = {1'b0, alt, 5'b0};
        end
        send(enc_i(imm, rs1, f3, rd, OP_IMM), 16'h0200, a, b, h, red, rpc);
        check_out(1'b1, 1'b0);
        // Only a right shift picks the alternate operation
        check_op("ex_alu_op", ex_alu_op, {(f3 == 3'b101) & alt, f3});
        check_bit("ex_alu_src", ex_alu_src, 1'b1);
        check_word("ex_imm", ex_imm, {{20{imm[11]}}, imm});
      end
      check_word("ex_rs1_data", ex_rs1_data, a);
      check_reg("ex_rs1", ex_rs1, rs1);
      check_reg("ex_rd", ex_rd, rd);
      check_bit("ex_reg_write", ex_reg_write, 1'b1);
      @(posedge bus);
    end
  endtask

  task automatic test_mem();
    logic [11:0] imm;
    logic [19:0] uimm;
    int          h;
    logic        red;
    logic [PC_W-1:0] rpc;
    imm = rand32();
    send(enc_i(imm, 5'd6, 3'b010, 5'd5, OP_LOAD), 16'h0300, rand32(), 0, h, red, rpc);
    check_out(1'b1, 1'b0);
    check_word("ex_imm", ex_imm, {{20{imm[11]}}, imm});
    check_op("ex_mem_size", {1'b0, ex_mem_size}, 4'd2);
    check_bit("ex_mem_read", ex_mem_read, 1'b1);
    check_bit("ex_mem_write", ex_mem_write, 1'b0);
    check_bit("ex_reg_write", ex_reg_write, 1'b1);
    @(posedge bus);
    imm = rand32();
    send({imm[11:5], 5'd11, 5'd12, 3'b000, imm[4:0], OP_STORE}, 16'h0304, 0, 0, h, red, rpc);
    check_out(1'b1, 1'b0);
    check_word("ex_imm", ex_imm, {{20{imm[11]}}, imm});
    check_op("ex_mem_size", {1'b0, ex_mem_size}, 4'd0);
    check_bit("ex_mem_read", ex_mem_read, 1'b0);
    check_bit("ex_mem_write", ex_mem_write, 1'b1);
    check_bit("ex_reg_write", ex_reg_write, 1'b0);
    @(posedge bus);
    uimm = rand32();
    send({uimm, 5'd3, OP_LUI}, 16'h0308, 0, 0, h, red, rpc);
    check_out(1'b1, 1'b0);
    check_word("ex_imm", ex_imm, {uimm, 12'h000});
    check_bit("ex_lui", ex_lui, 1'b1);
    @(posedge bus);
  endtask

  task automatic test_branch();
    logic [2:0]  conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0] a, b, wrong;
    logic [12:0] off;
    logic [20:0] joff;
    logic [PC_W-1:0] pc, rpc;
    logic        exp, red;
    int          h;
    for (int n = 0; n < 12; n++) begin
      a = rand32();
      b = (n >= 6) ? a : rand32();
      off = {rand32(), 1'b0};
      pc = rand32() & 16'hfffc;
      case (conds[n % 6])
        3'd0: exp = a == b;
        3'd1: exp = a != b;
        3'd4: exp = $signed(a) < $signed(b);
        3'd5: exp = $signed(a) >= $signed(b);
        3'd6: exp = a < b;
        default: exp = a >= b;
      endcase
      send({off[12], off[10:5], 5'd2, 5'd1, conds[n % 6], off[4:1], off[11], OP_BRANCH},
           pc, a, b, h, red, rpc);
      check_bit("redirect", red, exp);
      if (exp) begin
        check_word("redirect_pc", {16'h0, rpc}, {16'h0, pc + {{3{off[12]}}, off}});
        // Wrong-path word follows at once and must vanish
        wrong = enc_i(12'h001, 5'd1, 3'b000, 5'd31, OP_IMM);
        send(wrong, pc + 16'd4, 0, 0, h, red, rpc);
        check_out(1'b0, 1'b0);
      end else begin
        check_out(1'b1, 1'b0);
      end
      check_word("ex_pc", {16'h0, ex_pc}, {16'h0, pc});
      @(posedge bus);
    end
    joff = {rand32(), 1'b0};
    pc = 16'h4000;
    send({joff[20], joff[10:1], joff[11], joff[19:12], 5'd1, OP_JAL}, pc, 0, 0, h, red, rpc);
    check_bit("redirect", red, 1'b1);
    check_word("redirect_pc", {16'h0, rpc}, {16'h0, pc + joff[15:0]});
    // The jump issues, the word behind it is dropped
    wrong = enc_i(12'h001, 5'd1, 3'b000, 5'd31, OP_IMM);
    send(wrong, pc + 16'd4, 0, 0, h, red, rpc);
    check_out(1'b0, 1'b0);
    check_bit("ex_jal", ex_jal, 1'b1);
    check_word("ex_pc", {16'h0, ex_pc}, {16'h0, pc});
    @(posedge bus);
  endtask

  // Producer followed directly by a consumer
  task automatic hazard_pair(input logic [31:0] first, input logic [31:0] second,
                             input int exp_holds);
    int          h;
    logic        red;
    logic [PC_W-1:0] rpc;
    send(first, 16'h0500, 0, 0, h, red, rpc);
    send(second, 16'h0504, 0, 0, h, red, rpc);
    if (h != exp_holds) begin
      fail_run($sformatf("Load-use hold lasted %0d cycles instead of %0d", h, exp_holds));
    end
    check_out(1'b1, 1'b0);
    check_word("ex_pc", {16'h0, ex_pc}, 32'h0504);
    @(posedge bus);
  endtask

  task automatic test_load_use();
    hazard_pair(enc_i(12'h0, 5'd2, 3'b010, 5'd7, OP_LOAD), enc_r(0, 5'd3, 5'd7, 0, 5'd8), 1);
    hazard_pair(enc_i(12'h0, 5'd2, 3'b010, 5'd7, OP_LOAD), enc_r(0, 5'd7, 5'd3, 0, 5'd8), 1);
    hazard_pair(enc_i(12'h0, 5'd2, 3'b010, 5'd0, OP_LOAD), enc_r(0, 5'd3, 5'd0, 0, 5'd8), 0);
    hazard_pair(enc_i(12'h4, 5'd2, 3'b000, 5'd9, OP_IMM), enc_r(0, 5'd3, 5'd9, 0, 5'd8), 0);
  endtask

  task automatic test_credit();
    int          h;
    logic        red;
    logic [PC_W-1:0] rpc;
    // Let outstanding credits come back first
    repeat (3) @(posedge bus);
    auto_return = 1'b0;
    for (int n = 0; n < CREDITS; n++) begin
      send(enc_i(12'h0, 5'd1, 3'b000, 5'(n + 1), OP_IMM), 16'h0600, 0, 0, h, red, rpc);
      check_out(1'b1, 1'b0);
      @(posedge bus);
    end
    for (int n = 0; n < 2; n++) begin
      instr_valid <= 1'b1;
      instr       <= enc_i(12'h0, 5'd1, 3'b000, 5'(n + 20), OP_IMM);
      repeat (3) begin
        @(negedge bus);
        check_bit("hold", hold, 1'b1);
        check_bit("ex_valid", ex_valid, 1'b0);
        @(posedge bus);
      end
      credit_return <= 1'b1;
      @(negedge bus);
      check_bit("hold", hold, 1'b0);
      @(posedge bus);
      credit_return <= 1'b0;
      instr_valid   <= 1'b0;
      check_out(1'b1, 1'b0);
      check_reg("ex_rd", ex_rd, 5'(n + 20));
      @(posedge bus);
    end
    return_credits(CREDITS);
    auto_return = 1'b1;
  endtask

  task automatic test_illegal();
    int          h;
    logic        red;
    logic [PC_W-1:0] rpc;
    logic [31:0] bits;
    repeat (3) @(posedge bus);
    auto_return = 1'b0;
    // More illegal words than credits
    for (int n = 0; n < CREDITS + 1; n++) begin
      bits = rand32();
      send({bits[24:0], 7'b0010111}, 16'h0700, 0, 0, h, red, rpc);
      check_out(1'b0, 1'b1);
      @(posedge bus);
    end
    for (int n = 0; n < CREDITS; n++) begin
      send(enc_i(12'h0, 5'd1, 3'b000, 5'd4, OP_IMM), 16'h0710, 0, 0, h, red, rpc);
      if (h != 0) begin
        fail_run("Illegal words consumed execute credits");
      end
      check_out(1'b1, 1'b0);
      @(posedge bus);
    end
    return_credits(CREDITS);
    auto_return = 1'b1;
  endtask

  initial begin
    #(N_INSTR * 20 * 100);
    fail_run("Watchdog expired before the tests completed");
  end

  initial begin
    rng           = 32'd40248;
    errors        = 0;
    auto_return   = 1'b1;
    instr_valid   = 1'b0;
    instr         = '0;
    instr_pc      = '0;
    rs1_data      = '0;
    rs2_data      = '0;
    credit_return = 1'b0;
    @(posedge bus);
    while (reset) @(posedge bus);
    @(negedge bus);
    check_bit("ex_valid", ex_valid, 1'b0);
    check_bit("hold", hold, 1'b0);
    check_bit("redirect", redirect, 1'b0);
    check_bit("illegal", illegal, 1'b0);
    check_bit("ex_mem_read", ex_mem_read, 1'b0);
    check_bit("ex_mem_write", ex_mem_write, 1'b0);
    check_bit("ex_reg_write", ex_reg_write, 1'b0);
    @(posedge bus);
    test_alu();
    test_mem();
    test_branch();
    test_load_use();
    test_credit();
    test_illegal();
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
hdl/decode_pkg.sv
hdl/control_decoder.sv
hdl/imm_gen.sv
hdl/branch_unit.sv
hdl/credit_counter.sv
hdl/decode_fsm.sv
hdl/id_ex_reg.sv
hdl/decode_stage.sv
verif/tb_clock.sv
verif/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - hdl/decode_pkg.sv
  - hdl/control_decoder.sv
  - hdl/imm_gen.sv
  - hdl/branch_unit.sv
  - hdl/credit_counter.sv
  - hdl/decode_fsm.sv
  - hdl/id_ex_reg.sv
  - hdl/decode_stage.sv
  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/tb_decode_stage.sv
